// ==== wb_stage.f ====
logic/wb_pkg.sv
logic/wb_flags.sv
logic/wb_branch_resolve.sv
logic/wb_commit_gate.sv
logic/wb_operand_select.sv
logic/wb_stage.sv
verification/wb_stage_checker.sv
verification/wb_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the writeback stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module wb_stage_tb -f wb_stage.f -o wb_stage_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/wb_stage_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verification/wb_stage_tb.sv ====
`timescale 1ns/1ps

module wb_stage_tb;

   localparam int NUM_TRANS  = 2000;
   localparam int MAX_ROUNDS = 8 * NUM_TRANS;
   localparam int WAIT_LIMIT = 200;

   logic             clk;
   logic             reset;
   logic             in_valid;
   logic             in_ready;
   wb_pkg::wb_ctrl_t ctrl;
   logic [1:0]       datasize;
   logic             ex_ld_gpr1, ex_ld_gpr2, ex_dcache_write, repne;
   logic [31:0]      neip, neip_not_taken;
   logic [15:0]      ncs;
   logic [31:0]      result_a, result_b, result_c;
   logic [63:0]      result_mm;
   logic [31:0]      flags_in;
   logic [2:0]       dr1, dr2;
   logic [31:0]      address;
   logic             dcache_ready;

   logic [2:0]       dr1_out, dr2_out, dr3_out;
   logic [31:0]      data1_out, data2_out, data3_out;
   logic             ld_gpr1, ld_gpr2, ld_gpr3;
   logic [1:0]       datasize_out, dr3_datasize;
   logic             ld_seg, ld_mm, ld_eip, ld_cs, ld_flags;
   logic [63:0]      mm_data;
   logic [31:0]      eip;
   logic [15:0]      cs;
   logic [31:0]      flags_out;
   logic [63:0]      dcache_data;
   logic [31:0]      dcache_addr;
   logic             dcache_write;
   logic             halt, repne_terminate, branch_taken;
   logic [31:0]      flags_fwd, count_fwd;

   int               error_count;
   int               check_count;
   int               write_count;
   logic [31:0]      lcg_state;

   wb_stage u_wb_stage (.*);

   wb_stage_checker u_wb_stage_checker (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // roughly 70 percent ready
   task automatic drive_ready();
      logic [31:0] r;
      r = next_rand();
      dcache_ready = r[31:24] >= 8'd77;
   endtask

   task automatic drive_instruction();
      logic [31:0] r;
      logic [31:0] s;
      r = next_rand();
      s = next_rand();
      in_valid                = r[31:24] < 8'd205;
      ctrl.ld_gpr3            = r[0];
      ctrl.dr3                = r[3:1];
      ctrl.ld_seg             = r[4];
      ctrl.ld_mm              = r[5];
      ctrl.ld_flags           = r[6];
      ctrl.ld_eip             = r[7];
      ctrl.ld_cs              = r[8];
      // popf only together with a flags load
      ctrl.pop_flags          = r[6] & r[9] & r[10];
      ctrl.flags_affected     = r[16:11];
      ctrl.is_halt            = r[23:17] < 7'd6;
      // at most one of jne, jnbe, cmovc
      ctrl.is_jne             = s[1:0] == 2'd1;
      ctrl.is_jnbe            = s[1:0] == 2'd2;
      ctrl.is_cmovc           = s[1:0] == 2'd3;
      ctrl.is_cmps_first      = s[3:2] == 2'd1;
      ctrl.is_cmps_second     = s[3:2] == 2'd2;
      ctrl.save_neip          = s[4];
      ctrl.save_ncs           = s[5];
      ctrl.push_flags         = s[6] & s[7];
      ctrl.use_temp_neip      = s[8];
      ctrl.use_temp_ncs       = s[9];
      ctrl.mm_mem             = s[10];
      repne                   = s[11];
      ex_ld_gpr1              = s[12];
      ex_ld_gpr2              = s[13];
      ex_dcache_write         = s[14];
      datasize                = s[16:15];
      dr1                     = s[19:17];
      dr2                     = s[22:20];
      neip                    = next_rand();
      neip_not_taken          = next_rand();
      r                       = next_rand();
      ncs                     = r[15:0];
      result_a                = next_rand();
      result_b                = next_rand();
      // a zero count now and then ends the repne loop
      result_c                = (r[31:30] == 2'd0) ? 32'd0 : next_rand();
      result_mm               = {next_rand(), next_rand()};
      flags_in                = next_rand();
      address                 = next_rand();
   endtask

   initial begin
      int   trans_count;
      int   write_trans;
      int   tb_errors;
      int   rounds;
      int   wait_cycles;
      logic timed_out;
      lcg_state       = 32'h6d3f509b;
      reset           = 1'b1;
      in_valid        = 1'b0;
      ctrl            = '0;
      datasize        = 2'd0;
      ex_ld_gpr1      = 1'b0;
      ex_ld_gpr2      = 1'b0;
      ex_dcache_write = 1'b0;
      repne           = 1'b0;
      neip            = 32'd0;
      neip_not_taken  = 32'd0;
      ncs             = 16'd0;
      result_a        = 32'd0;
      result_b        = 32'd0;
      result_c        = 32'd0;
      result_mm       = 64'd0;
      flags_in        = 32'd0;
      dr1             = 3'd0;
      dr2             = 3'd0;
      address         = 32'd0;
      dcache_ready    = 1'b0;
      trans_count     = 0;
      write_trans     = 0;
      tb_errors       = 0;
      rounds          = 0;
      timed_out       = 1'b0;

      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      while (trans_count < NUM_TRANS && !timed_out && rounds < MAX_ROUNDS) begin
         rounds++;
         drive_instruction();
         drive_ready();
         @(posedge clk);
         if (in_valid) begin
            wait_cycles = 0;
            // hold the instruction until the stage accepts it
            while (!in_ready && wait_cycles < WAIT_LIMIT) begin
               @(negedge clk);
               drive_ready();
               @(posedge clk);
               wait_cycles++;
            end
            if (in_ready) begin
               trans_count++;
               if (ex_dcache_write) begin
                  write_trans++;
               end
            end else begin
               $display("timeout: stage did not accept an instruction in %0d cycles",
                        WAIT_LIMIT);
               tb_errors++;
               timed_out = 1'b1;
            end
         end
         @(negedge clk);
      end

      if (!timed_out && trans_count < NUM_TRANS) begin
         $display("run stopped after %0d rounds with only %0d transactions",
                  rounds, trans_count);
         tb_errors++;
      end
      if (write_count != write_trans) begin
         $display("cache accepted %0d writes but %0d write instructions committed",
                  write_count, write_trans);
         tb_errors++;
      end

      $display("transactions %0d, checks %0d, checker errors %0d, testbench errors %0d",
               trans_count, check_count, error_count, tb_errors);
      if (error_count == 0 && tb_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== verification/wb_stage_checker.sv ====
`timescale 1ns/1ps

module wb_stage_checker (
   input  logic             clk,
   input  logic             reset,
   input  logic             in_valid,
   input  logic             in_ready,
   input  wb_pkg::wb_ctrl_t ctrl,
   input  logic [1:0]       datasize,
   input  logic             ex_ld_gpr1, ex_ld_gpr2, ex_dcache_write, repne,
   input  logic [31:0]      neip, neip_not_taken,
   input  logic [15:0]      ncs,
   input  logic [31:0]      result_a, result_b, result_c,
   input  logic [63:0]      result_mm,
   input  logic [31:0]      flags_in,
   input  logic [2:0]       dr1, dr2,
   input  logic [31:0]      address,
   input  logic             dcache_ready,
   input  logic [2:0]       dr1_out, dr2_out, dr3_out,
   input  logic [31:0]      data1_out, data2_out, data3_out,
   input  logic             ld_gpr1, ld_gpr2, ld_gpr3,
   input  logic [1:0]       datasize_out, dr3_datasize,
   input  logic             ld_seg, ld_mm, ld_eip, ld_cs, ld_flags,
   input  logic [63:0]      mm_data,
   input  logic [31:0]      eip,
   input  logic [15:0]      cs,
   input  logic [31:0]      flags_out,
   input  logic [63:0]      dcache_data,
   input  logic [31:0]      dcache_addr,
   input  logic             dcache_write,
   input  logic             halt, repne_terminate, branch_taken,
   input  logic [31:0]      flags_fwd, count_fwd,
   output int               error_count,
   output int               check_count,
   output int               write_count
);

   // model state
   logic [31:0] flags_q;
   logic [31:0] saved_neip;
   logic [15:0] saved_ncs;
   logic [31:0] count_q;
   logic        prev_stall;
   logic [31:0] prev_addr;
   logic [63:0] prev_data;

   // affected bits in CF, PF, AF, ZF, SF, OF order
   function automatic logic [31:0] affected_mask(input logic [5:0] aff);
      logic [31:0] m;
      m = 32'd0;
      m[wb_pkg::CF_BIT] = aff[0];
      m[wb_pkg::PF_BIT] = aff[1];
      m[wb_pkg::AF_BIT] = aff[2];
      m[wb_pkg::ZF_BIT] = aff[3];
      m[wb_pkg::SF_BIT] = aff[4];
      m[wb_pkg::OF_BIT] = aff[5];
      return m;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   always @(posedge clk) begin : compare
      logic [31:0] mask;
      logic [31:0] exp_flags;
      logic [31:0] exp_data1;
      logic [31:0] exp_eip;
      logic [15:0] exp_cs;
      logic [63:0] exp_dc_data;
      logic        cf;
      logic        zf;
      logic        taken;
      logic        not_taken;
      logic        exp_write;
      logic        exp_ready;
      logic        commit;
      logic        repne_op;
      logic        exp_term;
      if (reset) begin
         flags_q     = wb_pkg::FLAGS_RESET;
         saved_neip  = 32'd0;
         saved_ncs   = 16'd0;
         count_q     = 32'd0;
         prev_stall  = 1'b0;
         error_count = 0;
         check_count = 0;
         write_count = 0;
      end else begin
         mask = affected_mask(ctrl.flags_affected);
         if (!ctrl.ld_flags) begin
            exp_flags = flags_q;
         end else if (ctrl.pop_flags) begin
            exp_flags = result_a;
         end else begin
            exp_flags = (flags_q & ~mask) | (flags_in & mask);
         end
         cf = exp_flags[wb_pkg::CF_BIT];
         zf = exp_flags[wb_pkg::ZF_BIT];
         taken     = (ctrl.is_jne & ~zf) | (ctrl.is_jnbe & ~cf & ~zf);
         not_taken = (ctrl.is_jne | ctrl.is_jnbe) & ~taken;

         exp_write = in_valid & ex_dcache_write;
         exp_ready = ~(exp_write & ~dcache_ready);
         commit    = in_valid & exp_ready;
         repne_op  = in_valid & ctrl.is_cmps_second & repne;
         exp_term  = repne_op & (zf | (result_c == 32'd0));

         if (ctrl.push_flags) begin
            exp_data1 = exp_flags;
         end else if (ctrl.save_neip) begin
            exp_data1 = neip;
         end else begin
            exp_data1 = result_a;
         end
         if (ctrl.use_temp_neip) begin
            exp_eip = saved_neip;
         end else begin
            exp_eip = not_taken ? neip_not_taken : neip;
         end
         exp_cs      = ctrl.use_temp_ncs ? saved_ncs : ncs;
         exp_dc_data = ctrl.mm_mem ? result_mm : {32'd0, exp_data1};

         check_value("in_ready", 64'(in_ready), 64'(exp_ready));
         check_value("dcache_write", 64'(dcache_write), 64'(exp_write));
         check_value("ld_gpr1", 64'(ld_gpr1), 64'(commit & ex_ld_gpr1));
         check_value("ld_gpr2", 64'(ld_gpr2),
                     64'(commit & ex_ld_gpr2 & (~ctrl.is_cmovc | cf)));
         check_value("ld_gpr3", 64'(ld_gpr3), 64'(commit & ctrl.ld_gpr3));
         check_value("ld_seg", 64'(ld_seg), 64'(commit & ctrl.ld_seg));
         check_value("ld_mm", 64'(ld_mm), 64'(commit & ctrl.ld_mm));
         check_value("ld_flags", 64'(ld_flags), 64'(commit & ctrl.ld_flags));
         check_value("ld_eip", 64'(ld_eip),
                     64'(commit & ctrl.ld_eip & ~(repne_op & ~exp_term)));
         check_value("ld_cs", 64'(ld_cs), 64'(commit & ctrl.ld_cs));
         check_value("halt", 64'(halt), 64'(commit & ctrl.is_halt));
         check_value("repne_terminate", 64'(repne_terminate), 64'(exp_term));
         check_value("branch_taken", 64'(branch_taken), 64'(taken & in_valid));
         check_value("dr1_out", 64'(dr1_out), 64'(dr1));
         check_value("dr2_out", 64'(dr2_out), 64'(dr2));
         check_value("dr3_out", 64'(dr3_out), 64'(ctrl.dr3));
         check_value("data1_out", 64'(data1_out), 64'(exp_data1));
         check_value("data2_out", 64'(data2_out), 64'(result_b));
         check_value("data3_out", 64'(data3_out), 64'(result_c));
         check_value("datasize_out", 64'(datasize_out), 64'(datasize));
         check_value("dr3_datasize", 64'(dr3_datasize), 64'(wb_pkg::DR3_DATASIZE));
         check_value("mm_data", mm_data, result_mm);
         check_value("eip", 64'(eip), 64'(exp_eip));
         check_value("cs", 64'(cs), 64'(exp_cs));
         check_value("flags_out", 64'(flags_out), 64'(exp_flags));
         check_value("flags_fwd", 64'(flags_fwd), 64'(exp_flags));
         check_value("count_fwd", 64'(count_fwd), 64'(count_q));
         check_value("dcache_data", dcache_data, exp_dc_data);
         check_value("dcache_addr", 64'(dcache_addr), 64'(address));

         // a stalled write must not move
         if (prev_stall) begin
            check_value("dcache_write held", 64'(dcache_write), 64'd1);
            check_value("dcache_addr held", 64'(dcache_addr), 64'(prev_addr));
            check_value("dcache_data held", dcache_data, prev_data);
         end

         if (commit) begin
            if (ctrl.ld_flags) begin
               flags_q = exp_flags;
            end
            if (ctrl.save_neip) begin
               saved_neip = neip;
            end
            if (ctrl.save_ncs) begin
               saved_ncs = ncs;
            end
            if (ctrl.is_cmps_second) begin
               count_q = result_c;
            end
         end
         if (dcache_write && dcache_ready) begin
            write_count++;
         end
         prev_stall = dcache_write & ~dcache_ready;
         prev_addr  = dcache_addr;
         prev_data  = dcache_data;
      end
   end

endmodule

// ==== logic/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
   input  logic             clk,
   input  logic             reset,

   input  logic             in_valid,
   output logic             in_ready,
   input  wb_pkg::wb_ctrl_t ctrl,
   // generated in decode, not from the control store
   input  logic [1:0]       datasize,
   input  logic             ex_ld_gpr1,
   input  logic             ex_ld_gpr2,
   input  logic             ex_dcache_write,
   input  logic             repne,

   input  logic [31:0]      neip,
   input  logic [31:0]      neip_not_taken,
   input  logic [15:0]      ncs,
   input  logic [31:0]      result_a,
   input  logic [31:0]      result_b,
   input  logic [31:0]      result_c,
   input  logic [63:0]      result_mm,
   input  logic [31:0]      flags_in,
   input  logic [2:0]       dr1,
   input  logic [2:0]       dr2,
   input  logic [31:0]      address,
   input  logic             dcache_ready,

   // general register file
   output logic [2:0]       dr1_out,
   output logic [2:0]       dr2_out,
   output logic [2:0]       dr3_out,
   output logic [31:0]      data1_out,
   output logic [31:0]      data2_out,
   output logic [31:0]      data3_out,
   output logic             ld_gpr1,
   output logic             ld_gpr2,
   output logic             ld_gpr3,
   output logic [1:0]       datasize_out,
   output logic [1:0]       dr3_datasize,

   output logic             ld_seg,
   output logic [63:0]      mm_data,
   output logic             ld_mm,
   output logic [31:0]      eip,
   output logic             ld_eip,
   output logic [15:0]      cs,
   output logic             ld_cs,
   output logic [31:0]      flags_out,
   output logic             ld_flags,

   output logic [63:0]      dcache_data,
   output logic [31:0]      dcache_addr,
   output logic             dcache_write,

   output logic             halt,
   output logic             repne_terminate,
   output logic             branch_taken,

   output logic [31:0]      flags_fwd,
   output logic [31:0]      count_fwd
);

   logic        commit;
   logic        taken;
   logic        use_not_taken;
   logic        ld_gpr2_req;
   logic [31:0] flags_merged;
   logic [31:0] data1;
   logic [31:0] count;

   wb_flags u_wb_flags (
      .clk       (clk),
      .reset     (reset),
      .ctrl      (ctrl),
      .flags_in  (flags_in),
      .result_a  (result_a),
      .commit    (commit),
      .flags_out (flags_merged)
   );

   wb_branch_resolve u_wb_branch_resolve (
      .ctrl          (ctrl),
      .flags         (flags_merged),
      .ex_ld_gpr2    (ex_ld_gpr2),
      .taken         (taken),
      .use_not_taken (use_not_taken),
      .ld_gpr2_req   (ld_gpr2_req)
   );

   // result_c carries the decremented count into the repne check
   wb_commit_gate u_wb_commit_gate (
      .in_valid        (in_valid),
      .ex_ld_gpr1      (ex_ld_gpr1),
      .ld_gpr2_req     (ld_gpr2_req),
      .ex_dcache_write (ex_dcache_write),
      .repne           (repne),
      .ctrl            (ctrl),
      .flags           (flags_merged),
      .count_next      (result_c),
      .dcache_ready    (dcache_ready),
      .in_ready        (in_ready),
      .commit          (commit),
      .ld_gpr1         (ld_gpr1),
      .ld_gpr2         (ld_gpr2),
      .ld_gpr3         (ld_gpr3),
      .ld_seg          (ld_seg),
      .ld_mm           (ld_mm),
      .ld_flags        (ld_flags),
      .ld_eip          (ld_eip),
      .ld_cs           (ld_cs),
      .dcache_write    (dcache_write),
      .halt            (halt),
      .repne_terminate (repne_terminate)
   );

   wb_operand_select u_wb_operand_select (
      .clk            (clk),
      .reset          (reset),
      .commit         (commit),
      .ctrl           (ctrl),
      .result_a       (result_a),
      .result_c       (result_c),
      .neip           (neip),
      .neip_not_taken (neip_not_taken),
      .ncs            (ncs),
      .flags          (flags_merged),
      .use_not_taken  (use_not_taken),
      .data1          (data1),
      .eip            (eip),
      .cs             (cs),
      .count          (count)
   );

   assign dr1_out      = dr1;
   assign dr2_out      = dr2;
   assign dr3_out      = ctrl.dr3;
   assign data1_out    = data1;
   assign data2_out    = result_b;
   assign data3_out    = result_c;
   assign datasize_out = datasize;
   assign dr3_datasize = wb_pkg::DR3_DATASIZE;

   assign mm_data   = result_mm;
   assign flags_out = flags_merged;

   // cache port is 64 wide for mmx stores
   assign dcache_data = ctrl.mm_mem ? result_mm : {32'd0, data1};
   assign dcache_addr = address;

   assign branch_taken = taken & in_valid;

   assign flags_fwd = flags_merged;
   assign count_fwd = count;

   // execute must hold the stalled write until the cache takes it
   a_dcache_hold : assert property (
      @(posedge clk) disable iff (reset)
      dcache_write && !dcache_ready |=>
         dcache_write && $stable(dcache_addr) && $stable(dcache_data)
   );

endmodule

// ==== logic/wb_operand_select.sv ====
`timescale 1ns/1ps

module wb_operand_select (
   input  logic             clk,
   input  logic             reset,
   input  logic             commit,
   input  wb_pkg::wb_ctrl_t ctrl,
   input  logic [31:0]      result_a,
   input  logic [31:0]      result_c,
   input  logic [31:0]      neip,
   input  logic [31:0]      neip_not_taken,
   input  logic [15:0]      ncs,
   input  logic [31:0]      flags,
   input  logic             use_not_taken,
   output logic [31:0]      data1,
   output logic [31:0]      eip,
   output logic [15:0]      cs,
   output logic [31:0]      count
);

   logic [31:0] saved_neip;
   logic [15:0] saved_ncs;

   // pushf wins over the return-address push
   always_comb begin
      if (ctrl.push_flags) begin
         data1 = flags;
      end else if (ctrl.save_neip) begin
         data1 = neip;
      end else begin
         data1 = result_a;
      end
   end

   always_comb begin
      if (ctrl.use_temp_neip) begin
         eip = saved_neip;
      end else if (use_not_taken) begin
         eip = neip_not_taken;
      end else begin
         eip = neip;
      end
   end

   assign cs = ctrl.use_temp_ncs ? saved_ncs : ncs;

   // far transfer targets held for the second micro-op
   always_ff @(posedge clk) begin
      if (reset) begin
         saved_neip <= '0;
         saved_ncs  <= '0;
         count      <= '0;
      end else if (commit) begin
         if (ctrl.save_neip) begin
            saved_neip <= neip;
         end
         if (ctrl.save_ncs) begin
            saved_ncs <= ncs;
         end
         // ecx after this cmps iteration
         if (ctrl.is_cmps_second) begin
            count <= result_c;
         end
      end
   end

endmodule

// ==== logic/wb_commit_gate.sv ====
`timescale 1ns/1ps

module wb_commit_gate (
   input  logic             in_valid,
   input  logic             ex_ld_gpr1,
   input  logic             ld_gpr2_req,
   input  logic             ex_dcache_write,
   input  logic             repne,
   input  wb_pkg::wb_ctrl_t ctrl,
   input  logic [31:0]      flags,
   input  logic [31:0]      count_next,
   input  logic             dcache_ready,
   output logic             in_ready,
   output logic             commit,
   output logic             ld_gpr1,
   output logic             ld_gpr2,
   output logic             ld_gpr3,
   output logic             ld_seg,
   output logic             ld_mm,
   output logic             ld_flags,
   output logic             ld_eip,
   output logic             ld_cs,
   output logic             dcache_write,
   output logic             halt,
   output logic             repne_terminate
);

   logic stall;
   logic repne_cmps;
   logic repeat_cmps;

   // write request stays up until the cache takes it
   assign dcache_write = in_valid & ex_dcache_write;
   assign stall        = dcache_write & ~dcache_ready;
   assign in_ready     = ~stall;
   assign commit       = in_valid & in_ready;

   assign repne_cmps = in_valid & ctrl.is_cmps_second & repne;

   // stop on a match or when the count runs out
   assign repne_terminate = repne_cmps &
                            (flags[wb_pkg::ZF_BIT] | (count_next == 32'd0));

   // keep eip on the string op so it runs again
   assign repeat_cmps = repne_cmps & ~repne_terminate;

   assign ld_gpr1  = commit & ex_ld_gpr1;
   assign ld_gpr2  = commit & ld_gpr2_req;
   assign ld_gpr3  = commit & ctrl.ld_gpr3;
   assign ld_seg   = commit & ctrl.ld_seg;
   assign ld_mm    = commit & ctrl.ld_mm;
   assign ld_flags = commit & ctrl.ld_flags;
   assign ld_eip   = commit & ctrl.ld_eip & ~repeat_cmps;
   assign ld_cs    = commit & ctrl.ld_cs;

   assign halt = commit & ctrl.is_halt;

endmodule

// ==== logic/wb_branch_resolve.sv ====
`timescale 1ns/1ps

module wb_branch_resolve (
   input  wb_pkg::wb_ctrl_t ctrl,
   input  logic [31:0]      flags,
   input  logic             ex_ld_gpr2,
   output logic             taken,
   output logic             use_not_taken,
   output logic             ld_gpr2_req
);

   logic cf;
   logic zf;
   logic jne_taken;
   logic jnbe_taken;
   logic is_cond_branch;

   assign cf = flags[wb_pkg::CF_BIT];
   assign zf = flags[wb_pkg::ZF_BIT];

   assign jne_taken  = ctrl.is_jne & ~zf;
   // above means neither carry nor zero
   assign jnbe_taken = ctrl.is_jnbe & ~cf & ~zf;

   assign taken          = jne_taken | jnbe_taken;
   assign is_cond_branch = ctrl.is_jne | ctrl.is_jnbe;

   // fall through to the next sequential eip
   assign use_not_taken = is_cond_branch & ~taken;

   // cmovc only writes its destination when carry is set
   assign ld_gpr2_req = ex_ld_gpr2 & (~ctrl.is_cmovc | cf);

endmodule

// ==== logic/wb_flags.sv ====
`timescale 1ns/1ps

module wb_flags (
   input  logic             clk,
   input  logic             reset,
   input  wb_pkg::wb_ctrl_t ctrl,
   input  logic [31:0]      flags_in,
   input  logic [31:0]      result_a,
   input  logic             commit,
   output logic [31:0]      flags_out
);

   logic [31:0] flags_q;
   logic [31:0] mask;
   logic [31:0] merged;

   assign mask   = wb_pkg::flags_mask(ctrl.flags_affected);
   // only the affected flags come from execute
   assign merged = (flags_q & ~mask) | (flags_in & mask);

   always_comb begin
      if (!ctrl.ld_flags) begin
         flags_out = flags_q;
      end else if (ctrl.pop_flags) begin
         // popf takes the whole word off the stack
         flags_out = result_a;
      end else begin
         flags_out = merged;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         flags_q <= wb_pkg::FLAGS_RESET;
      end else if (commit && ctrl.ld_flags) begin
         flags_q <= flags_out;
      end
   end

   // a pop must also load the flags, or the popped value is lost
   a_pop_needs_ld : assert property (
      @(posedge clk) disable iff (reset)
      commit && ctrl.pop_flags |-> ctrl.ld_flags
   );

endmodule

// ==== logic/wb_pkg.sv ====
package wb_pkg;

   // writeback slice of the control store
   typedef struct packed {
      logic       ld_gpr3;
      logic [2:0] dr3;
      logic       ld_seg;
      logic       ld_mm;
      logic       ld_flags;
      logic       ld_eip;
      logic       ld_cs;
      logic       pop_flags;
      // one bit per flag from cf at [0] up to of at [5]
      logic [5:0] flags_affected;
      logic       is_halt;
      logic       is_jne;
      logic       is_jnbe;
      logic       is_cmovc;
      logic       is_cmps_first;
      logic       is_cmps_second;
      logic       save_neip;
      logic       save_ncs;
      logic       push_flags;
      logic       use_temp_neip;
      logic       use_temp_ncs;
      logic       mm_mem;
   } wb_ctrl_t;

   // eflags bit positions
   localparam int CF_BIT = 0;
   localparam int PF_BIT = 2;
   localparam int AF_BIT = 4;
   localparam int ZF_BIT = 6;
   localparam int SF_BIT = 7;
   localparam int OF_BIT = 11;

   // bit 1 of eflags always reads as one
   localparam logic [31:0] FLAGS_RESET  = 32'h0000_0002;
   // doubleword size code
   localparam logic [1:0]  DR3_DATASIZE = 2'b10;

   // expand the per-flag update bits into a full eflags mask
   function automatic logic [31:0] flags_mask(input logic [5:0] affected);
      logic [31:0] mask;
      mask = '0;
      mask[CF_BIT] = affected[0];
      mask[PF_BIT] = affected[1];
      mask[AF_BIT] = affected[2];
      mask[ZF_BIT] = affected[3];
      mask[SF_BIT] = affected[4];
      mask[OF_BIT] = affected[5];
      return mask;
   endfunction

endpackage
